// ==== src/cpuPkg.sv ====
// Shared types and encodings for the integer execution pipeline.
// Every stage and the testbench reach these through cpuPkg:: scoped names.
package cpuPkg;

    typedef logic [31:0] wordT;    // data word
    typedef logic [4:0]  regIdxT;  // register number
    typedef logic [3:0]  aluOpT;
    typedef logic [2:0]  excCodeT;

    // alu operation codes
    localparam aluOpT aluAdd  = 4'd0;
    localparam aluOpT aluSub  = 4'd1;
    localparam aluOpT aluSlt  = 4'd2;
    localparam aluOpT aluSltu = 4'd3;
    localparam aluOpT aluAnd  = 4'd4;
    localparam aluOpT aluOr   = 4'd5;
    localparam aluOpT aluXor  = 4'd6;
    localparam aluOpT aluNor  = 4'd7;
    localparam aluOpT aluSll  = 4'd8;
    localparam aluOpT aluSrl  = 4'd9;
    localparam aluOpT aluSra  = 4'd10;
    localparam aluOpT aluLui  = 4'd11;

    // exception codes reported at retirement
    localparam excCodeT excNone     = 3'd0;
    localparam excCodeT excReserved = 3'd1;
    localparam excCodeT excOverflow = 3'd2;
    localparam excCodeT excSyscall  = 3'd3;
    localparam excCodeT excBreak    = 3'd4;

    // operand b source
    localparam logic srcBReg = 1'b0;
    localparam logic srcBImm = 1'b1;

    // shift amount source
    localparam logic shiftImm = 1'b0;  // shamt field
    localparam logic shiftVar = 1'b1;  // low bits of rs

    // immediate extension
    localparam logic extZero = 1'b0;
    localparam logic extSign = 1'b1;

endpackage

// ==== src/instrDecode.sv ====
// Decode stage. Classifies one instruction per strobe by opcode and function
// and registers the control fields for the operand stage.
`timescale 1ns/10ps

module instrDecode (
    input  logic           clk,
    input  logic           rstN,
    input  logic           instrValid,
    input  cpuPkg::wordT   instr,
    output logic           decValid,
    output cpuPkg::aluOpT  decAluOp,
    output cpuPkg::regIdxT decRs,
    output cpuPkg::regIdxT decRt,
    output cpuPkg::regIdxT decDst,
    output logic           decWrEn,
    output logic           decSrcB,
    output logic           decShiftSel,
    output logic           decExtOp,
    output logic [15:0]    decImm,
    output logic [4:0]     decShamt,
    output logic           decCheckOvf,
    output cpuPkg::excCodeT decExc
);

    logic [5:0]      opcode;
    logic [5:0]      funct;
    cpuPkg::regIdxT  rs;
    cpuPkg::regIdxT  rt;
    cpuPkg::regIdxT  rd;
    logic [4:0]      shamt;
    cpuPkg::aluOpT   shiftOp;
    cpuPkg::aluOpT   aluOp;
    logic            useRd;
    logic            wrEn;
    logic            srcB;
    logic            shiftSel;
    logic            extOp;
    logic            checkOvf;
    cpuPkg::excCodeT exc;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];

    // funct[1:0] picks the shift kind in both shift groups
    assign shiftOp = funct[1] ? (funct[0] ? cpuPkg::aluSra : cpuPkg::aluSrl) : cpuPkg::aluSll;

    always_comb begin
        aluOp    = cpuPkg::aluAdd;
        useRd    = 1'b1;
        wrEn     = 1'b1;
        srcB     = cpuPkg::srcBReg;
        shiftSel = cpuPkg::shiftImm;
        extOp    = cpuPkg::extSign;
        checkOvf = 1'b0;
        exc      = cpuPkg::excNone;
        casez (opcode)
            6'b000000: begin // register group
                case (funct)
                    6'b100000: begin // add
                        aluOp    = cpuPkg::aluAdd;
                        checkOvf = 1'b1;
                    end
                    6'b100001: aluOp = cpuPkg::aluAdd; // addu
                    6'b100010: begin // sub
                        aluOp    = cpuPkg::aluSub;
                        checkOvf = 1'b1;
                    end
                    6'b100011: aluOp = cpuPkg::aluSub; // subu
                    6'b101010: aluOp = cpuPkg::aluSlt;
                    6'b101011: aluOp = cpuPkg::aluSltu;
                    6'b100100: aluOp = cpuPkg::aluAnd;
                    6'b100101: aluOp = cpuPkg::aluOr;
                    6'b100110: aluOp = cpuPkg::aluXor;
                    6'b100111: aluOp = cpuPkg::aluNor;
                    6'b000000, 6'b000010, 6'b000011: begin // sll srl sra
                        aluOp = shiftOp;
                        if (rs != 5'd0)
                            exc = cpuPkg::excReserved;
                    end
                    6'b000100, 6'b000110, 6'b000111: begin // sllv srlv srav
                        aluOp    = shiftOp;
                        shiftSel = cpuPkg::shiftVar;
                        if (shamt != 5'd0)
                            exc = cpuPkg::excReserved;
                    end
                    6'b001100: exc = cpuPkg::excSyscall;
                    6'b001101: exc = cpuPkg::excBreak;
                    default:   exc = cpuPkg::excReserved;
                endcase
            end
            6'b001???: begin // immediate group, result goes to rt
                useRd = 1'b0;
                srcB  = cpuPkg::srcBImm;
                case (opcode[2:0])
                    3'b000: begin // addi
                        aluOp    = cpuPkg::aluAdd;
                        checkOvf = 1'b1;
                    end
                    3'b001: aluOp = cpuPkg::aluAdd;  // addiu
                    3'b010: aluOp = cpuPkg::aluSlt;  // slti
                    3'b011: aluOp = cpuPkg::aluSltu; // sltiu, still sign extended
                    3'b100: begin
                        aluOp = cpuPkg::aluAnd;
                        extOp = cpuPkg::extZero;
                    end
                    3'b101: begin
                        aluOp = cpuPkg::aluOr;
                        extOp = cpuPkg::extZero;
                    end
                    3'b110: begin
                        aluOp = cpuPkg::aluXor;
                        extOp = cpuPkg::extZero;
                    end
                    default: begin // lui
                        aluOp = cpuPkg::aluLui;
                        extOp = cpuPkg::extZero;
                    end
                endcase
            end
            default: exc = cpuPkg::excReserved; // loads, branches, cop0 and the rest
        endcase
        if (exc != cpuPkg::excNone)
            wrEn = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            decValid <= 1'b0;
        else
            decValid <= instrValid;
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            decAluOp    <= aluOp;
            decRs       <= rs;
            decRt       <= rt;
            decDst      <= useRd ? rd : rt;
            decWrEn     <= wrEn;
            decSrcB     <= srcB;
            decShiftSel <= shiftSel;
            decExtOp    <= extOp;
            decImm      <= instr[15:0];
            decShamt    <= shamt;
            decCheckOvf <= checkOvf;
            decExc      <= exc;
        end
    end

endmodule

// ==== src/regFile.sv ====
// 32-entry register file, two read ports and one write port.
// Register zero reads as zero and a same-cycle write is seen by the reads.
`timescale 1ns/10ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  logic           wrEn,
    input  cpuPkg::regIdxT wrIdx,
    input  cpuPkg::wordT   wrData,
    input  cpuPkg::regIdxT rdIdxA,
    input  cpuPkg::regIdxT rdIdxB,
    output cpuPkg::wordT   rdDataA,
    output cpuPkg::wordT   rdDataB
);

    cpuPkg::wordT regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wrEn && wrIdx != 5'd0) begin
            regs[wrIdx] <= wrData;
        end
    end

    always_comb begin
        rdDataA = (rdIdxA == 5'd0) ? '0 : regs[rdIdxA];
        rdDataB = (rdIdxB == 5'd0) ? '0 : regs[rdIdxB];
        if (wrEn && wrIdx != 5'd0 && wrIdx == rdIdxA)
            rdDataA = wrData; // write-through
        if (wrEn && wrIdx != 5'd0 && wrIdx == rdIdxB)
            rdDataB = wrData;
    end

endmodule

// ==== src/operandStage.sv ====
// Operand stage. Reads both sources from the register file, extends the
// immediate into operand b and registers operands and control for the ALU.
`timescale 1ns/10ps

module operandStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            decValid,
    input  cpuPkg::aluOpT   decAluOp,
    input  cpuPkg::regIdxT  decRs,
    input  cpuPkg::regIdxT  decRt,
    input  cpuPkg::regIdxT  decDst,
    input  logic            decWrEn,
    input  logic            decSrcB,
    input  logic            decShiftSel,
    input  logic            decExtOp,
    input  logic [15:0]     decImm,
    input  logic [4:0]      decShamt,
    input  logic            decCheckOvf,
    input  cpuPkg::excCodeT decExc,
    output cpuPkg::regIdxT  rfIdxA,
    output cpuPkg::regIdxT  rfIdxB,
    input  cpuPkg::wordT    rfDataA,
    input  cpuPkg::wordT    rfDataB,
    output logic            opValid,
    output cpuPkg::wordT    opA,
    output cpuPkg::wordT    opB,
    output cpuPkg::regIdxT  opRs,
    output cpuPkg::regIdxT  opRt,
    output logic [4:0]      opShamt,
    output cpuPkg::aluOpT   opAluOp,
    output cpuPkg::regIdxT  opDst,
    output logic            opWrEn,
    output logic            opCheckOvf,
    output cpuPkg::excCodeT opExc
);

    cpuPkg::wordT immExt;
    logic         useImm;

    assign rfIdxA = decRs;
    assign rfIdxB = decRt;
    assign useImm = (decSrcB == cpuPkg::srcBImm);
    assign immExt = (decExtOp == cpuPkg::extSign) ? {{16{decImm[15]}}, decImm} : {16'd0, decImm};

    always_ff @(posedge clk) begin
        if (!rstN)
            opValid <= 1'b0;
        else
            opValid <= decValid;
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            opA        <= rfDataA;
            opB        <= useImm ? immExt : rfDataB;
            opRs       <= decRs;
            opRt       <= useImm ? 5'd0 : decRt; // zero index never matches the bypass
            opShamt    <= (decShiftSel == cpuPkg::shiftVar) ? 5'd0 : decShamt;
            opAluOp    <= decAluOp;
            opDst      <= decDst;
            opWrEn     <= decWrEn;
            opCheckOvf <= decCheckOvf;
            opExc      <= decExc;
        end
    end

endmodule

// ==== src/aluStage.sv ====
// Execute stage. Bypasses from its own result register, runs the ALU
// operation, flags signed overflow and registers the result.
`timescale 1ns/10ps

module aluStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            opValid,
    input  cpuPkg::wordT    opA,
    input  cpuPkg::wordT    opB,
    input  cpuPkg::regIdxT  opRs,
    input  cpuPkg::regIdxT  opRt,
    input  logic [4:0]      opShamt,
    input  cpuPkg::aluOpT   opAluOp,
    input  cpuPkg::regIdxT  opDst,
    input  logic            opWrEn,
    input  logic            opCheckOvf,
    input  cpuPkg::excCodeT opExc,
    output logic            exValid,
    output cpuPkg::wordT    exResult,
    output cpuPkg::regIdxT  exDst,
    output logic            exWrEn,
    output cpuPkg::excCodeT exExc
);

    logic         fwdOk;
    cpuPkg::wordT a;
    cpuPkg::wordT b;
    cpuPkg::wordT result;
    logic [4:0]   shAmt;
    logic         ovf;

    // previous instruction writes a nonzero register
    assign fwdOk = exValid && exWrEn && exDst != 5'd0;
    assign a     = (fwdOk && exDst == opRs) ? exResult : opA;
    assign b     = (fwdOk && exDst == opRt) ? exResult : opB;

    // decode makes one of the two zero
    assign shAmt = a[4:0] | opShamt;

    always_comb begin
        ovf = 1'b0;
        case (opAluOp)
            cpuPkg::aluAdd: begin
                result = a + b;
                ovf    = (a[31] == b[31]) && (result[31] != a[31]);
            end
            cpuPkg::aluSub: begin
                result = a - b;
                ovf    = (a[31] != b[31]) && (result[31] != a[31]);
            end
            cpuPkg::aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
            cpuPkg::aluSltu: result = {31'd0, a < b};
            cpuPkg::aluAnd:  result = a & b;
            cpuPkg::aluOr:   result = a | b;
            cpuPkg::aluXor:  result = a ^ b;
            cpuPkg::aluNor:  result = ~(a | b);
            cpuPkg::aluSll:  result = b << shAmt;
            cpuPkg::aluSrl:  result = b >> shAmt;
            cpuPkg::aluSra:  result = $unsigned($signed(b) >>> shAmt);
            default:         result = {b[15:0], 16'd0}; // lui
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            exValid <= 1'b0;
        else
            exValid <= opValid;
    end

    always_ff @(posedge clk) begin
        if (opValid) begin
            exResult <= result;
            exDst    <= opDst;
            if (opExc == cpuPkg::excNone && opCheckOvf && ovf) begin
                exWrEn <= 1'b0;
                exExc  <= cpuPkg::excOverflow;
            end else begin
                exWrEn <= opWrEn;
                exExc  <= opExc;
            end
        end
    end

endmodule

// ==== src/writebackStage.sv ====
// Writeback stage. Writes the register file from the execute hand-off and
// registers the retirement and exception outputs.
`timescale 1ns/10ps

module writebackStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            exValid,
    input  cpuPkg::wordT    exResult,
    input  cpuPkg::regIdxT  exDst,
    input  logic            exWrEn,
    input  cpuPkg::excCodeT exExc,
    output logic            rfWrEn,
    output cpuPkg::regIdxT  rfWrIdx,
    output cpuPkg::wordT    rfWrData,
    output logic            wbValid,
    output cpuPkg::regIdxT  wbDst,
    output cpuPkg::wordT    wbData,
    output logic            excValid,
    output cpuPkg::excCodeT excCode
);

    // register zero and excepting instructions never write
    assign rfWrEn   = exValid && exWrEn && exDst != 5'd0 && exExc == cpuPkg::excNone;
    assign rfWrIdx  = exDst;
    assign rfWrData = exResult;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid  <= 1'b0;
            excValid <= 1'b0;
        end else begin
            wbValid  <= rfWrEn;
            excValid <= exValid && exExc != cpuPkg::excNone;
        end
    end

    always_ff @(posedge clk) begin
        wbDst   <= exDst;
        wbData  <= exResult;
        excCode <= exExc;
    end

endmodule

// ==== src/coreTop.sv ====
// Top level of the integer pipeline: decode, operand read, execute and
// writeback around a shared register file. Results retire four cycles after
// the instruction strobe.
`timescale 1ns/10ps

module coreTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            instrValid,
    input  cpuPkg::wordT    instr,
    output logic            wbValid,
    output cpuPkg::regIdxT  wbDst,
    output cpuPkg::wordT    wbData,
    output logic            excValid,
    output cpuPkg::excCodeT excCode
);

    logic            decValid;
    cpuPkg::aluOpT   decAluOp;
    cpuPkg::regIdxT  decRs;
    cpuPkg::regIdxT  decRt;
    cpuPkg::regIdxT  decDst;
    logic            decWrEn;
    logic            decSrcB;
    logic            decShiftSel;
    logic            decExtOp;
    logic [15:0]     decImm;
    logic [4:0]      decShamt;
    logic            decCheckOvf;
    cpuPkg::excCodeT decExc;

    cpuPkg::regIdxT  rfIdxA;
    cpuPkg::regIdxT  rfIdxB;
    cpuPkg::wordT    rfDataA;
    cpuPkg::wordT    rfDataB;
    logic            rfWrEn;
    cpuPkg::regIdxT  rfWrIdx;
    cpuPkg::wordT    rfWrData;

    logic            opValid;
    cpuPkg::wordT    opA;
    cpuPkg::wordT    opB;
    cpuPkg::regIdxT  opRs;
    cpuPkg::regIdxT  opRt;
    logic [4:0]      opShamt;
    cpuPkg::aluOpT   opAluOp;
    cpuPkg::regIdxT  opDst;
    logic            opWrEn;
    logic            opCheckOvf;
    cpuPkg::excCodeT opExc;

    logic            exValid;
    cpuPkg::wordT    exResult;
    cpuPkg::regIdxT  exDst;
    logic            exWrEn;
    cpuPkg::excCodeT exExc;

    instrDecode decode0 (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .decValid(decValid), .decAluOp(decAluOp), .decRs(decRs), .decRt(decRt),
        .decDst(decDst), .decWrEn(decWrEn), .decSrcB(decSrcB),
        .decShiftSel(decShiftSel), .decExtOp(decExtOp), .decImm(decImm),
        .decShamt(decShamt), .decCheckOvf(decCheckOvf), .decExc(decExc)
    );

    regFile regFile0 (
        .clk(clk), .rstN(rstN), .wrEn(rfWrEn), .wrIdx(rfWrIdx), .wrData(rfWrData),
        .rdIdxA(rfIdxA), .rdIdxB(rfIdxB), .rdDataA(rfDataA), .rdDataB(rfDataB)
    );

    operandStage operand0 (
        .clk(clk), .rstN(rstN), .decValid(decValid), .decAluOp(decAluOp),
        .decRs(decRs), .decRt(decRt), .decDst(decDst), .decWrEn(decWrEn),
        .decSrcB(decSrcB), .decShiftSel(decShiftSel), .decExtOp(decExtOp),
        .decImm(decImm), .decShamt(decShamt), .decCheckOvf(decCheckOvf),
        .decExc(decExc), .rfIdxA(rfIdxA), .rfIdxB(rfIdxB), .rfDataA(rfDataA),
        .rfDataB(rfDataB), .opValid(opValid), .opA(opA), .opB(opB), .opRs(opRs),
        .opRt(opRt), .opShamt(opShamt), .opAluOp(opAluOp), .opDst(opDst),
        .opWrEn(opWrEn), .opCheckOvf(opCheckOvf), .opExc(opExc)
    );

    aluStage alu0 (
        .clk(clk), .rstN(rstN), .opValid(opValid), .opA(opA), .opB(opB),
        .opRs(opRs), .opRt(opRt), .opShamt(opShamt), .opAluOp(opAluOp),
        .opDst(opDst), .opWrEn(opWrEn), .opCheckOvf(opCheckOvf), .opExc(opExc),
        .exValid(exValid), .exResult(exResult), .exDst(exDst), .exWrEn(exWrEn),
        .exExc(exExc)
    );

    writebackStage writeback0 (
        .clk(clk), .rstN(rstN), .exValid(exValid), .exResult(exResult),
        .exDst(exDst), .exWrEn(exWrEn), .exExc(exExc), .rfWrEn(rfWrEn),
        .rfWrIdx(rfWrIdx), .rfWrData(rfWrData), .wbValid(wbValid), .wbDst(wbDst),
        .wbData(wbData), .excValid(excValid), .excCode(excCode)
    );

endmodule

// ==== test/coreTbTasks.svh ====
// Instruction encoders, compare tasks, the LFSR source and the directed tests.
// Included into the body of the pipeline testbench module.
`ifndef coreTbTasksSvh
`define coreTbTasksSvh

localparam logic [59:0] arithFns = {6'h27, 6'h26, 6'h25, 6'h24, 6'h2b,
                                    6'h2a, 6'h23, 6'h22, 6'h21, 6'h20};
localparam logic [17:0] shiftFns = {6'h03, 6'h02, 6'h00};  // sra srl sll

// galois lfsr, one step per bit handed out
function automatic logic [31:0] lfsrBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsrState[0]};
        lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
    end
    return r;
endfunction

function automatic cpuPkg::wordT rType(input logic [5:0] fn, input cpuPkg::regIdxT rd,
                                       input cpuPkg::regIdxT rs, input cpuPkg::regIdxT rt,
                                       input logic [4:0] sa);
    return {6'd0, rs, rt, rd, sa, fn};
endfunction

function automatic cpuPkg::wordT iType(input logic [5:0] opc, input cpuPkg::regIdxT rt,
                                       input cpuPkg::regIdxT rs, input logic [15:0] imm);
    return {opc, rs, rt, imm};
endfunction

task automatic flagFailure(input string msg);
    errCount++;
    $display("Error: %s (cycle %0d)", msg, cycleCnt);
endtask

task automatic checkWord(input string name, input cpuPkg::wordT got, input cpuPkg::wordT exp);
    checkCount++;
    if (got !== exp) begin
        errCount++;
        $display("** Error: %s = %h, expected %h (cycle %0d)", name, got, exp, cycleCnt);
    end
endtask

task automatic checkReg(input string name, input cpuPkg::regIdxT got,
                       input cpuPkg::regIdxT exp);
    checkCount++;
    if (got !== exp) begin
        errCount++;
        $display("** Error: %s = %h, expected %h (cycle %0d)", name, got, exp, cycleCnt);
    end
endtask

task automatic checkExc(input string name, input cpuPkg::excCodeT got,
                        input cpuPkg::excCodeT exp);
    checkCount++;
    if (got !== exp) begin
        errCount++;
        $display("** Error: %s = %h, expected %h (cycle %0d)", name, got, exp, cycleCnt);
    end
endtask

task automatic loadReg(input cpuPkg::regIdxT r, input cpuPkg::wordT v, input int gap);
    issue(iType(6'h0f, r, 5'd0, v[31:16]), gap);  // lui
    issue(iType(6'h0d, r, r, v[15:0]), gap);      // ori
endtask

task automatic testArith();
    for (int r = 0; r < rounds; r++) begin
        loadReg(5'd1, lfsrBits(32), 0);
        loadReg(5'd2, lfsrBits(32), 0);
        for (int k = 0; k < 10; k++)
            issue(rType(arithFns[6 * k +: 6], 5'(3 + k), 5'd1, 5'd2, 5'd0), 0);
    end
    finishTest("r-type arithmetic");
endtask

task automatic testImm();
    logic [15:0] imm;
    for (int r = 0; r < rounds; r++) begin
        loadReg(5'd1, lfsrBits(32), 0);
        for (int k = 0; k < 8; k++) begin
            imm = 16'(lfsrBits(16)) | (r[0] ? 16'h8000 : 16'h0000);  // odd rounds negative
            issue(iType(6'(8 + k), 5'(4 + k), (k == 7) ? 5'd0 : 5'd1, imm), 0);
        end
    end
    finishTest("immediate group");
endtask

task automatic testShift();
    cpuPkg::wordT val;
    for (int r = 0; r < rounds; r++) begin
        val = lfsrBits(32);
        if (r[0])
            val[31] = 1'b1;
        loadReg(5'd1, val, 0);
        loadReg(5'd2, lfsrBits(32), 0);
        for (int k = 0; k < 3; k++)
            issue(rType(shiftFns[6 * k +: 6], 5'(3 + k), 5'd0, 5'd1, 5'(lfsrBits(5))), 0);
        for (int k = 0; k < 3; k++)
            issue(rType(shiftFns[6 * k +: 6] | 6'h04, 5'(6 + k), 5'd2, 5'd1, 5'd0), 0);
    end
    finishTest("shifts");
endtask

task automatic testDeps();
    cpuPkg::regIdxT prev;
    cpuPkg::regIdxT dst;
    cpuPkg::wordT   ins;
    for (int g = 0; g < 3; g++) begin
        loadReg(5'd1, lfsrBits(32), g);
        loadReg(5'd2, lfsrBits(32), g);
        prev = 5'd1;
        for (int j = 0; j < 8; j++) begin
            dst = 5'(16 + j);
            case (j % 4)
                0: ins = rType(6'h21, dst, prev, 5'd2, 5'd0);   // addu, prev on a
                1: ins = rType(6'h23, dst, 5'd2, prev, 5'd0);   // subu, prev on b
                2: ins = iType(6'h09, dst, prev, 16'(lfsrBits(16)));
                default: ins = rType(6'h06, dst, prev, 5'd2, 5'd0);  // srlv by prev
            endcase
            issue(ins, g);
            prev = dst;
        end
    end
    finishTest("back-to-back chains");
endtask

task automatic testExc();
    loadReg(5'd1, 32'h7fffffff, 0);
    loadReg(5'd2, 32'h80000000, 0);
    loadReg(5'd3, 32'h00000001, 0);
    for (int k = 0; k < 5; k++)
        loadReg(5'(10 + k), lfsrBits(32), 0);
    issue(rType(6'h20, 5'd10, 5'd1, 5'd1, 5'd0), 0);  // add overflow
    issue(rType(6'h22, 5'd11, 5'd2, 5'd3, 5'd0), 0);  // sub overflow
    issue(iType(6'h08, 5'd12, 5'd1, 16'h0001), 0);
    issue(rType(6'h0c, 5'd0, 5'd0, 5'd0, 5'd0), 0);
    issue(rType(6'h0d, 5'd0, 5'd0, 5'd0, 5'd0), 0);
    issue(iType(6'h23, 5'd13, 5'd1, 16'h0004), 0);    // lw
    issue(rType(6'h04, 5'd14, 5'd2, 5'd1, 5'd3), 0);  // sllv with shamt set
    for (int k = 4; k >= 0; k--)
        issue(rType(6'h25, 5'(20 + k), 5'(10 + k), 5'd0, 5'd0), 0);
    finishTest("exceptions");
endtask

task automatic testZero();
    loadReg(5'd1, lfsrBits(32), 0);
    issue(rType(6'h21, 5'd0, 5'd1, 5'd1, 5'd0), 0);
    issue(iType(6'h0d, 5'd0, 5'd1, 16'hffff), 0);
    issue(rType(6'h25, 5'd21, 5'd0, 5'd0, 5'd0), 0);
    issue(iType(6'h09, 5'd22, 5'd0, 16'(lfsrBits(16))), 0);
    finishTest("register zero");
endtask

`endif

// ==== test/coreTb.sv ====
// Testbench for the integer pipeline. Keeps a reference register file, predicts
// each retirement when its instruction is strobed, and checks the DUT outputs
// in order against those predictions. Test tasks come from the included header.
`timescale 1ns/10ps

module coreTb;

    typedef struct packed {
        logic            isExc;
        cpuPkg::regIdxT  dst;
        cpuPkg::wordT    data;
        cpuPkg::excCodeT code;
        logic [31:0]     cycle;  // cycle in which the retirement is due
    } retireT;

    localparam int rounds = 6;
    localparam int instrTotal = rounds * (14 + 10 + 10) + 36 + 28 + 6;
    // up to 3 cycles per instruction plus drain time for each of 6 tests
    localparam int watchdogCycles = instrTotal * 3 + 6 * 30 + 20;

    logic            clk;
    logic            rstN;
    logic            instrValid;
    cpuPkg::wordT    instr;
    logic            wbValid;
    cpuPkg::regIdxT  wbDst;
    cpuPkg::wordT    wbData;
    logic            excValid;
    cpuPkg::excCodeT excCode;

    cpuPkg::wordT    refRegs [32];
    retireT          expQ [$];
    logic [31:0]     lfsrState = 32'h7224e82e;
    int              cycleCnt = 0;
    int              errCount = 0;
    int              checkCount = 0;
    int              testCount = 0;
    int              failCount = 0;
    int              errMark = 0;

    coreTop dut0 (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .wbValid(wbValid), .wbDst(wbDst), .wbData(wbData),
        .excValid(excValid), .excCode(excCode)
    );

    `include "coreTbTasks.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // outputs change on the rising edge, so look at them mid cycle
    always @(negedge clk) begin
        if (rstN && (wbValid || excValid))
            checkRetire();
    end

    // MIPS semantics applied to the reference registers in program order
    task automatic predict(input cpuPkg::wordT ins);
        logic [5:0]      opc;
        logic [5:0]      fn;
        logic [4:0]      sa;
        cpuPkg::regIdxT  rs;
        cpuPkg::regIdxT  rt;
        cpuPkg::regIdxT  dst;
        cpuPkg::wordT    a;
        cpuPkg::wordT    b;
        cpuPkg::wordT    sImm;
        cpuPkg::wordT    res;
        logic [32:0]     wide;
        cpuPkg::excCodeT code;
        retireT          e;
        opc  = ins[31:26];
        fn   = ins[5:0];
        sa   = ins[10:6];
        rs   = ins[25:21];
        rt   = ins[20:16];
        a    = refRegs[rs];
        b    = refRegs[rt];
        sImm = {{16{ins[15]}}, ins[15:0]};
        res  = '0;
        wide = '0;
        code = cpuPkg::excNone;
        dst  = ins[15:11];
        if (opc == 6'h00) begin
            case (fn)
                6'h20, 6'h21: begin
                    wide = {a[31], a} + {b[31], b};
                    res  = wide[31:0];
                    if (fn == 6'h20 && wide[32] != wide[31])
                        code = cpuPkg::excOverflow;
                end
                6'h22, 6'h23: begin
                    wide = {a[31], a} - {b[31], b};
                    res  = wide[31:0];
                    if (fn == 6'h22 && wide[32] != wide[31])
                        code = cpuPkg::excOverflow;
                end
                6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h27: res = ~(a | b);
                6'h00: res = b << sa;
                6'h02: res = b >> sa;
                6'h03: res = $signed(b) >>> sa;
                6'h04: res = b << a[4:0];
                6'h06: res = b >> a[4:0];
                6'h07: res = $signed(b) >>> a[4:0];
                6'h0c: code = cpuPkg::excSyscall;
                6'h0d: code = cpuPkg::excBreak;
                default: code = cpuPkg::excReserved;
            endcase
            if (fn inside {6'h00, 6'h02, 6'h03} && rs != 5'd0)
                code = cpuPkg::excReserved;  // fixed shift with rs set
            if (fn inside {6'h04, 6'h06, 6'h07} && sa != 5'd0)
                code = cpuPkg::excReserved;
        end else begin
            dst = rt;
            case (opc)
                6'h08, 6'h09: begin
                    wide = {a[31], a} + {sImm[31], sImm};
                    res  = wide[31:0];
                    if (opc == 6'h08 && wide[32] != wide[31])
                        code = cpuPkg::excOverflow;
                end
                6'h0a: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                6'h0b: res = (a < sImm) ? 32'd1 : 32'd0;
                6'h0c: res = a & {16'd0, ins[15:0]};
                6'h0d: res = a | {16'd0, ins[15:0]};
                6'h0e: res = a ^ {16'd0, ins[15:0]};
                6'h0f: res = {ins[15:0], 16'd0};
                default: code = cpuPkg::excReserved;
            endcase
        end
        e.isExc = (code != cpuPkg::excNone);
        e.dst   = dst;
        e.data  = res;
        e.code  = code;
        e.cycle = cycleCnt + 4;
        if (e.isExc) begin
            expQ.push_back(e);
        end else if (dst != 5'd0) begin  // r0 writes retire silently
            refRegs[dst] = res;
            expQ.push_back(e);
        end
    endtask

    task automatic checkRetire();
        retireT e;
        if (wbValid && excValid) begin
            flagFailure("wbValid and excValid are high in the same cycle");
        end else if (expQ.size() == 0) begin
            flagFailure("a result retired with no instruction outstanding");
        end else begin
            e = expQ.pop_front();
            if (e.cycle != cycleCnt)
                flagFailure($sformatf("retirement came in cycle %0d instead of cycle %0d",
                    cycleCnt, e.cycle));
            if (e.isExc && !excValid) begin
                flagFailure("an exception was expected but a register write retired");
            end else if (!e.isExc && !wbValid) begin
                flagFailure("a register write was expected but an exception was raised");
            end else if (e.isExc) begin
                checkExc("excCode", excCode, e.code);
            end else begin
                checkReg("wbDst", wbDst, e.dst);
                checkWord("wbData", wbData, e.data);
            end
        end
    endtask

    task automatic issue(input cpuPkg::wordT ins, input int gap);
        instrValid = 1'b1;
        instr      = ins;
        predict(ins);
        @(posedge clk);
        #5;
        instrValid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic finishTest(input string name);
        int waited;
        waited = 0;
        while (expQ.size() > 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (expQ.size() > 0) begin
            flagFailure($sformatf("%0d expected retirements never arrived", expQ.size()));
            expQ.delete();
        end
        repeat (6) @(posedge clk);  // catch stray retirements
        #5;
        testCount++;
        if (errCount == errMark) begin
            $display("test %-20s passed", name);
        end else begin
            $display("test %-20s FAILED with %0d errors", name, errCount - errMark);
            failCount++;
        end
        errMark = errCount;
    endtask

    initial begin
        #(watchdogCycles * 40);
        $display("Error: watchdog expired in cycle %0d, the run hung", cycleCnt);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        instrValid = 1'b0;
        instr      = '0;
        rstN       = 1'b0;
        for (int i = 0; i < 32; i++)
            refRegs[i] = '0;
        repeat (3) @(posedge clk);
        #5;
        rstN = 1'b1;
        testArith();
        testImm();
        testShift();
        testDeps();
        testExc();
        testZero();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            testCount, failCount, checkCount, errCount);
        if (errCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
src/cpuPkg.sv
src/instrDecode.sv
src/regFile.sv
src/operandStage.sv
src/aluStage.sv
src/writebackStage.sv
src/coreTop.sv
test/coreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the pipeline testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timescale 1ns/10ps --top-module coreTb -f vlog.f -o coreSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/coreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Done: errors found" "$logFile"; then
    exit 1
fi
if ! grep -q "Done: no errors" "$logFile"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
